//--- src.f
+incdir+hw
hw/riscv_isa_pkg.sv
hw/core_bus_pkg.sv
hw/imem_loader.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/core_top.sv
verification/core_checker.sv
verification/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hw/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qx 'TB PASSED' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/core_tb.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module core_tb;

    import core_bus_pkg::*;
    import riscv_isa_pkg::*;

    // Program lengths in words including four register setup words
    localparam int APB_WORDS   = 16;
    localparam int IMM_LEN     = 44;
    localparam int REG_LEN     = 44;
    localparam int DEP_LEN     = 52;
    localparam int COUNT_LEN   = 5;
    localparam int BUSY_LEN    = 12;
    localparam int TOTAL_WORDS = APB_WORDS + IMM_LEN + REG_LEN + DEP_LEN + COUNT_LEN + BUSY_LEN;
    localparam int WATCHDOG_NS = (TOTAL_WORDS * 20 + 1000) * 10;

    logic        clk;
    logic        rstn;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    retire_t     retire;
    logic [31:0] rng_state;
    logic [31:0] prog [$];
    int          retired;
    int          tests;
    int          failed;
    int          errors;

    core_top core_top_i (
        .clk       (clk),
        .rstn      (rstn),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .retire_o  (retire)
    );

    core_checker checker_i (
        .clk       (clk),
        .rstn      (rstn),
        .apb_req_i (apb_req),
        .apb_rsp_i (apb_rsp),
        .retire_i  (retire),
        .retired_o (retired),
        .tests_o   (tests),
        .failed_o  (failed),
        .errors_o  (errors)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function logic [4:0] rand_reg(int span);
        return 5'(rand_word() % 32'(span));
    endfunction

    // kind 0 register-immediate, 1 register-register, otherwise both
    function logic [31:0] gen_instr(int kind, int span);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          pick;
        r    = rand_word();
        rd   = rand_reg(span);
        rs1  = rand_reg(span);
        rs2  = rand_reg(span);
        pick = int'(rand_word() % 21);
        if (kind == 0) pick = pick % 11;
        else if (kind == 1) pick = 11 + pick % 10;
        case (pick)
            0:  return {r[31:12], rd, OPCODE_LUI};
            1:  return {r[31:12], rd, OPCODE_AUIPC};
            2:  return {r[11:0], rs1, F3_ADD_SUB, rd, OPCODE_OP_IMM};
            3:  return {r[11:0], rs1, F3_SLT, rd, OPCODE_OP_IMM};
            4:  return {r[11:0], rs1, F3_SLTU, rd, OPCODE_OP_IMM};
            5:  return {r[11:0], rs1, F3_XOR, rd, OPCODE_OP_IMM};
            6:  return {r[11:0], rs1, F3_OR, rd, OPCODE_OP_IMM};
            7:  return {r[11:0], rs1, F3_AND, rd, OPCODE_OP_IMM};
            8:  return {F7_BASE, r[4:0], rs1, F3_SLL, rd, OPCODE_OP_IMM};
            9:  return {F7_BASE, r[4:0], rs1, F3_SRL_SRA, rd, OPCODE_OP_IMM};
            10: return {F7_ALT, r[4:0], rs1, F3_SRL_SRA, rd, OPCODE_OP_IMM};
            11: return {F7_BASE, rs2, rs1, F3_ADD_SUB, rd, OPCODE_OP};
            12: return {F7_ALT, rs2, rs1, F3_ADD_SUB, rd, OPCODE_OP};
            13: return {F7_BASE, rs2, rs1, F3_SLL, rd, OPCODE_OP};
            14: return {F7_BASE, rs2, rs1, F3_SLT, rd, OPCODE_OP};
            15: return {F7_BASE, rs2, rs1, F3_SLTU, rd, OPCODE_OP};
            16: return {F7_BASE, rs2, rs1, F3_XOR, rd, OPCODE_OP};
            17: return {F7_BASE, rs2, rs1, F3_SRL_SRA, rd, OPCODE_OP};
            18: return {F7_ALT, rs2, rs1, F3_SRL_SRA, rd, OPCODE_OP};
            19: return {F7_BASE, rs2, rs1, F3_OR, rd, OPCODE_OP};
            default: return {F7_BASE, rs2, rs1, F3_AND, rd, OPCODE_OP};
        endcase
    endfunction

    task build_program(int len, int kind, int span);
        logic [31:0] r;
        int          k;
        prog.delete();
        // x1 and x3 get upper bits, x2 and x4 small signed values
        for (k = 1; k <= 4; k++) begin
            r = rand_word();
            if (k % 2 == 1) prog.push_back({r[31:12], 5'(k), OPCODE_LUI});
            else prog.push_back({r[11:0], 5'd0, F3_ADD_SUB, 5'(k), OPCODE_OP_IMM});
        end
        while (prog.size() < len) prog.push_back(gen_instr(kind, span));
    endtask

    task bus_transfer(logic write, logic [11:0] addr, logic [31:0] wdata,
                      output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!apb_rsp.pready && waits < 16) begin
            @(negedge clk);
            waits++;
        end
        if (!apb_rsp.pready) checker_i.report_text("APB access never got pready");
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task apb_write(logic [11:0] addr, logic [31:0] data, output logic err);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, data, unused, err);
    endtask

    task apb_read(logic [11:0] addr, output logic [31:0] data, output logic err);
        bus_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task run_program(string name);
        logic [31:0] rdata;
        logic        err;
        int          i;
        @(posedge clk);
        #1;
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        checker_i.begin_test(name);
        foreach (prog[j]) checker_i.add_word(prog[j]);
        for (i = 0; i < prog.size(); i++) apb_write(`IMEM_BASE + 12'(4 * i), prog[i], err);
        apb_write(`CTRL_ADDR, (32'd1 << `CTRL_RUN_BIT) | 32'(prog.size()), err);
        rdata = '0;
        i = 0;
        while (!rdata[0] && i < prog.size() + 16) begin
            apb_read(`STATUS_ADDR, rdata, err);
            i++;
        end
        if (!rdata[0]) checker_i.report_text("STATUS never reported done");
        i = 0;
        while (retired < prog.size() && i < 16) begin
            @(posedge clk);
            i++;
        end
        apb_read(`STATUS_ADDR, rdata, err);
    endtask

    task check_apb_map();
        logic [31:0] rdata;
        logic        err;
        int          i;
        checker_i.begin_test("apb_readback");
        for (i = 0; i < APB_WORDS; i++) begin
            apb_write(`IMEM_BASE + 12'(((i * 37) % `IMEM_DEPTH) * 4), rand_word(), err);
        end
        for (i = 0; i < APB_WORDS; i++) begin
            apb_read(`IMEM_BASE + 12'(((i * 37) % `IMEM_DEPTH) * 4), rdata, err);
        end
        // Holes in the address map
        apb_read(12'h008, rdata, err);
        apb_write(12'h3fc, 32'h1234_5678, err);
        apb_read(12'h800, rdata, err);
        checker_i.end_test(0);
    endtask

    task write_while_running();
        logic [31:0] rdata;
        logic        err;
        build_program(BUSY_LEN, 2, 5);
        run_program("busy_write");
        // Run stays set after done, so word 1 must be refused
        apb_write(`IMEM_BASE + 12'h004, ~prog[1], err);
        apb_read(`IMEM_BASE + 12'h004, rdata, err);
        apb_read(`CTRL_ADDR, rdata, err);
        checker_i.end_test(BUSY_LEN);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        apb_req   = '0;
        rng_state = 32'h5074_cf7e;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        check_apb_map();
        build_program(IMM_LEN, 0, 5);
        run_program("reg_imm");
        checker_i.end_test(IMM_LEN);
        build_program(REG_LEN, 1, 5);
        run_program("reg_reg");
        checker_i.end_test(REG_LEN);
        // Only x0 to x2 so most sources were written one to three slots earlier
        build_program(DEP_LEN, 2, 3);
        run_program("dependency");
        checker_i.end_test(DEP_LEN);
        build_program(COUNT_LEN, 2, 5);
        run_program("retire_count");
        checker_i.end_test(COUNT_LEN);
        write_while_running();

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verification/core_checker.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module core_checker (
    input  logic                   clk,
    input  logic                   rstn,
    input  core_bus_pkg::apb_req_t apb_req_i,
    input  core_bus_pkg::apb_rsp_t apb_rsp_i,
    input  core_bus_pkg::retire_t  retire_i,
    output int                     retired_o,
    output int                     tests_o,
    output int                     failed_o,
    output int                     errors_o
);

    import riscv_isa_pkg::*;

    string       test_name;
    int          test_errors;
    logic [31:0] prog [$];
    logic [31:0] regs [32];
    logic [31:0] shadow_mem [`IMEM_DEPTH];
    logic        shadow_known [`IMEM_DEPTH];
    logic        shadow_run;
    logic [8:0]  shadow_len;

    initial begin
        tests_o     = 0;
        failed_o    = 0;
        errors_o    = 0;
        retired_o   = 0;
        test_errors = 0;
        shadow_run  = 1'b0;
        shadow_len  = '0;
        foreach (shadow_known[i]) shadow_known[i] = 1'b0;
    end

    task begin_test(string name);
        test_name   = name;
        test_errors = 0;
        retired_o   = 0;
        prog.delete();
        foreach (regs[i]) regs[i] = '0;
    endtask

    task add_word(logic [31:0] word);
        prog.push_back(word);
    endtask

    task check_value(string what, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
            errors_o++;
        end
    endtask

    task report_text(string what);
        $display("%s: %s", test_name, what);
        test_errors++;
        errors_o++;
    endtask

    task end_test(int expected);
        check_value("retired record count", expected, retired_o);
        tests_o++;
        if (test_errors != 0) failed_o++;
        $display("%-14s %3d records  %0d errors  %s", test_name, retired_o, test_errors,
                 (test_errors == 0) ? "ok" : "failed");
    endtask

    // RV32I result from the raw instruction bits
    function automatic logic [31:0] model_result(logic [31:0] ins, logic [31:0] pc,
                                                 logic [31:0] a, logic [31:0] b);
        logic [31:0] imm_u;
        logic [31:0] op2;
        logic [4:0]  sh;
        logic        is_op;
        imm_u = {ins[31:12], 12'b0};
        is_op = ins[6:0] == OPCODE_OP;
        op2   = is_op ? b : {{20{ins[31]}}, ins[31:20]};
        sh    = op2[4:0];
        if (ins[6:0] == OPCODE_LUI) return imm_u;
        if (ins[6:0] == OPCODE_AUIPC) return pc + imm_u;
        case (ins[14:12])
            3'b000: return (is_op && ins[30]) ? a - op2 : a + op2;
            3'b001: return a << sh;
            3'b010: return {31'b0, $signed(a) < $signed(op2)};
            3'b011: return {31'b0, a < op2};
            3'b100: return a ^ op2;
            3'b101: begin
                if (ins[30]) return $unsigned($signed(a) >>> sh);
                return a >> sh;
            end
            3'b110: return a | op2;
            default: return a & op2;
        endcase
    endfunction

    task check_retire();
        logic [31:0] ins;
        logic [31:0] pc;
        logic [31:0] exp;
        string       tag;
        if (retired_o >= prog.size()) begin
            report_text($sformatf("unexpected retire record at pc %h", retire_i.pc));
        end else begin
            ins = prog[retired_o];
            pc  = `RESET_PC + 32'(4 * retired_o);
            exp = model_result(ins, pc, regs[ins[19:15]], regs[ins[24:20]]);
            tag = $sformatf("record %0d", retired_o);
            check_value({tag, " pc"}, pc, retire_i.pc);
            check_value({tag, " instr"}, ins, retire_i.instr);
            check_value({tag, " rd"}, 32'(ins[11:7]), 32'(retire_i.rd));
            check_value({tag, " we"}, 32'd1, 32'(retire_i.we));
            check_value({tag, " rd_data"}, exp, retire_i.rd_data);
            // x0 stays zero in the model
            if (ins[11:7] != 5'd0) regs[ins[11:7]] = exp;
        end
        retired_o++;
    endtask

    task check_apb();
        logic [11:0] addr;
        logic [7:0]  word;
        logic        in_imem;
        logic        exp_err;
        addr    = apb_req_i.paddr;
        word    = addr[9:2];
        in_imem = addr[11:10] == 2'b01;
        exp_err = !(in_imem || addr == `CTRL_ADDR || addr == `STATUS_ADDR) ||
                  (in_imem && apb_req_i.pwrite && shadow_run);
        check_value($sformatf("pslverr at %h", addr), 32'(exp_err), 32'(apb_rsp_i.pslverr));
        if (!exp_err && apb_req_i.pwrite) begin
            if (in_imem) begin
                shadow_mem[word]   = apb_req_i.pwdata;
                shadow_known[word] = 1'b1;
            end else if (addr == `CTRL_ADDR) begin
                shadow_run = apb_req_i.pwdata[`CTRL_RUN_BIT];
                shadow_len = apb_req_i.pwdata[8:0];
            end
        end else if (!exp_err) begin
            if (in_imem && shadow_known[word]) begin
                check_value($sformatf("imem read at %h", addr), shadow_mem[word],
                            apb_rsp_i.prdata);
            end else if (addr == `CTRL_ADDR) begin
                check_value("CTRL read", {shadow_run, 22'b0, shadow_len}, apb_rsp_i.prdata);
            end else if (addr == `STATUS_ADDR && shadow_run && prog.size() > 0 &&
                         retired_o == prog.size()) begin
                check_value("STATUS after last retire", 32'd1, apb_rsp_i.prdata);
            end
        end
    endtask

    // Sampled at mid-cycle
    always @(negedge clk) begin
        if (!rstn) begin
            shadow_run = 1'b0;
            shadow_len = '0;
        end else begin
            if (retire_i.valid) check_retire();
            if (apb_req_i.psel && apb_req_i.penable) check_apb();
        end
    end

endmodule

//--- hw/core_top.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module core_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  core_bus_pkg::apb_req_t apb_req_i,
    output core_bus_pkg::apb_rsp_t apb_rsp_o,
    output core_bus_pkg::retire_t  retire_o
);

    import core_bus_pkg::*;

    logic                  run;
    logic [`IMEM_AW:0]     prog_len;
    logic [`IMEM_AW-1:0]   fetch_addr;
    logic [`XLEN-1:0]      fetch_instr;
    logic                  done;
    if_id_t                if_id;
    id_ex_t                id_ex;
    id_ex_t                ex;
    logic [`XLEN-1:0]      result;
    reg_wr_t               reg_wr;

    imem_loader imem_loader_i (
        .clk           (clk),
        .rstn          (rstn),
        .apb_req_i     (apb_req_i),
        .fetch_addr_i  (fetch_addr),
        .done_i        (done),
        .apb_rsp_o     (apb_rsp_o),
        .fetch_instr_o (fetch_instr),
        .run_o         (run),
        .prog_len_o    (prog_len)
    );

    fetch_stage fetch_stage_i (
        .clk          (clk),
        .rstn         (rstn),
        .run_i        (run),
        .prog_len_i   (prog_len),
        .instr_i      (fetch_instr),
        .fetch_addr_o (fetch_addr),
        .if_id_o      (if_id),
        .done_o       (done)
    );

    decode_stage decode_stage_i (
        .clk      (clk),
        .rstn     (rstn),
        .if_id_i  (if_id),
        .reg_wr_i (reg_wr),
        .id_ex_o  (id_ex)
    );

    // Writeback result also serves as the forward source
    execute_stage execute_stage_i (
        .id_ex_i  (id_ex),
        .wb_fwd_i (reg_wr),
        .ex_o     (ex),
        .result_o (result)
    );

    writeback_stage writeback_stage_i (
        .clk      (clk),
        .rstn     (rstn),
        .ex_i     (ex),
        .result_i (result),
        .reg_wr_o (reg_wr),
        .retire_o (retire_o)
    );

endmodule

//--- hw/writeback_stage.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module writeback_stage (
    input  logic                  clk,
    input  logic                  rstn,
    input  core_bus_pkg::id_ex_t  ex_i,
    input  logic [`XLEN-1:0]      result_i,
    output core_bus_pkg::reg_wr_t reg_wr_o,
    output core_bus_pkg::retire_t retire_o
);

    import core_bus_pkg::*;

    retire_t wb_q;

    // EX/WB register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_q <= '0;
        end else begin
            wb_q.valid   <= ex_i.valid;
            wb_q.pc      <= ex_i.pc;
            wb_q.instr   <= ex_i.instr;
            wb_q.rd      <= ex_i.rd;
            wb_q.rd_data <= result_i;
            wb_q.we      <= ex_i.we;
        end
    end

    assign reg_wr_o.en   = wb_q.valid && wb_q.we && (wb_q.rd != '0);
    assign reg_wr_o.rd   = wb_q.rd;
    assign reg_wr_o.data = wb_q.rd_data;

    assign retire_o = wb_q;

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module execute_stage (
    input  core_bus_pkg::id_ex_t  id_ex_i,
    input  core_bus_pkg::reg_wr_t wb_fwd_i,
    output core_bus_pkg::id_ex_t  ex_o,
    output logic [`XLEN-1:0]      result_o
);

    import riscv_isa_pkg::*;

    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] imm;
    logic [4:0]       shamt_i;
    logic [4:0]       shamt_r;

    // Only one producer can be ahead of execute
    assign rs1 = (wb_fwd_i.en && wb_fwd_i.rd == id_ex_i.rs1) ? wb_fwd_i.data : id_ex_i.rs1_data;
    assign rs2 = (wb_fwd_i.en && wb_fwd_i.rd == id_ex_i.rs2) ? wb_fwd_i.data : id_ex_i.rs2_data;

    assign imm     = id_ex_i.imm;
    assign shamt_i = imm[4:0];
    assign shamt_r = rs2[4:0];

    always_comb begin
        result_o = '0;
        case (id_ex_i.op)
            OP_LUI:   result_o = imm;
            OP_AUIPC: result_o = id_ex_i.pc + imm;
            OP_ADDI:  result_o = rs1 + imm;
            OP_SLTI:  result_o = {{(`XLEN-1){1'b0}}, $signed(rs1) < $signed(imm)};
            OP_SLTIU: result_o = {{(`XLEN-1){1'b0}}, rs1 < imm};
            OP_XORI:  result_o = rs1 ^ imm;
            OP_ORI:   result_o = rs1 | imm;
            OP_ANDI:  result_o = rs1 & imm;
            OP_SLLI:  result_o = rs1 << shamt_i;
            OP_SRLI:  result_o = rs1 >> shamt_i;
            OP_SRAI:  result_o = $signed(rs1) >>> shamt_i;
            OP_ADD:   result_o = rs1 + rs2;
            OP_SUB:   result_o = rs1 - rs2;
            OP_SLL:   result_o = rs1 << shamt_r;
            OP_SLT:   result_o = {{(`XLEN-1){1'b0}}, $signed(rs1) < $signed(rs2)};
            OP_SLTU:  result_o = {{(`XLEN-1){1'b0}}, rs1 < rs2};
            OP_XOR:   result_o = rs1 ^ rs2;
            OP_OR:    result_o = rs1 | rs2;
            OP_AND:   result_o = rs1 & rs2;
            OP_SRL:   result_o = rs1 >> shamt_r;
            OP_SRA:   result_o = $signed(rs1) >>> shamt_r;
            default: ;
        endcase
    end

    assign ex_o = id_ex_i;

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rstn,
    input  core_bus_pkg::if_id_t  if_id_i,
    input  core_bus_pkg::reg_wr_t reg_wr_i,
    output core_bus_pkg::id_ex_t  id_ex_o
);

    import riscv_isa_pkg::*;

    instr_u           ins;
    operation_e       op;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] regs [32];

    assign ins = if_id_i.instr;

    always_comb begin
        op  = OP_UNKNOWN;
        imm = '0;
        case (ins.r.opcode)
            OPCODE_LUI: begin
                op  = OP_LUI;
                imm = {ins.u.imm20, 12'b0};
            end
            OPCODE_AUIPC: begin
                op  = OP_AUIPC;
                imm = {ins.u.imm20, 12'b0};
            end
            OPCODE_OP_IMM: begin
                imm = {{(`XLEN-12){ins.i.imm12[11]}}, ins.i.imm12};
                case (ins.i.funct3)
                    F3_ADD_SUB: op = OP_ADDI;
                    F3_SLT:     op = OP_SLTI;
                    F3_SLTU:    op = OP_SLTIU;
                    F3_XOR:     op = OP_XORI;
                    F3_OR:      op = OP_ORI;
                    F3_AND:     op = OP_ANDI;
                    // Shift kind sits in the funct7 field
                    F3_SLL: begin
                        if (ins.r.funct7 == F7_BASE) op = OP_SLLI;
                    end
                    F3_SRL_SRA: begin
                        if (ins.r.funct7 == F7_BASE) op = OP_SRLI;
                        else if (ins.r.funct7 == F7_ALT) op = OP_SRAI;
                    end
                    default: ;
                endcase
            end
            OPCODE_OP: begin
                if (ins.r.funct7 == F7_BASE) begin
                    case (ins.r.funct3)
                        F3_ADD_SUB: op = OP_ADD;
                        F3_SLL:     op = OP_SLL;
                        F3_SLT:     op = OP_SLT;
                        F3_SLTU:    op = OP_SLTU;
                        F3_XOR:     op = OP_XOR;
                        F3_SRL_SRA: op = OP_SRL;
                        F3_OR:      op = OP_OR;
                        F3_AND:     op = OP_AND;
                        default: ;
                    endcase
                end else if (ins.r.funct7 == F7_ALT) begin
                    if (ins.r.funct3 == F3_ADD_SUB) op = OP_SUB;
                    else if (ins.r.funct3 == F3_SRL_SRA) op = OP_SRA;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_wr_i.en) begin
            regs[reg_wr_i.rd] <= reg_wr_i.data;
        end
    end

    // x0 reads zero and a same-cycle write goes straight through
    always_comb begin
        if (ins.r.rs1 == '0) rs1_data = '0;
        else if (reg_wr_i.en && reg_wr_i.rd == ins.r.rs1) rs1_data = reg_wr_i.data;
        else rs1_data = regs[ins.r.rs1];

        if (ins.r.rs2 == '0) rs2_data = '0;
        else if (reg_wr_i.en && reg_wr_i.rd == ins.r.rs2) rs2_data = reg_wr_i.data;
        else rs2_data = regs[ins.r.rs2];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.valid    <= if_id_i.valid;
            id_ex_o.pc       <= if_id_i.pc;
            id_ex_o.instr    <= if_id_i.instr;
            id_ex_o.op       <= op;
            id_ex_o.rd       <= ins.r.rd;
            id_ex_o.rs1      <= ins.r.rs1;
            id_ex_o.rs2      <= ins.r.rs2;
            id_ex_o.rs1_data <= rs1_data;
            id_ex_o.rs2_data <= rs2_data;
            id_ex_o.imm      <= imm;
            id_ex_o.we       <= op != OP_UNKNOWN;
        end
    end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 run_i,
    input  logic [`IMEM_AW:0]    prog_len_i,
    input  logic [`XLEN-1:0]     instr_i,
    output logic [`IMEM_AW-1:0]  fetch_addr_o,
    output core_bus_pkg::if_id_t if_id_o,
    output logic                 done_o
);

    import core_bus_pkg::*;

    logic [`XLEN-1:0]  pc_q;
    logic [`IMEM_AW:0] count_q;
    logic              done_q;
    logic              issue;
    if_id_t            if_id_q;

    assign issue        = run_i && (count_q < prog_len_i);
    assign fetch_addr_o = pc_q[`IMEM_AW+1:2];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q    <= `RESET_PC;
            count_q <= '0;
            done_q  <= 1'b0;
            if_id_q <= '0;
        end else begin
            if_id_q.valid <= issue;
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= instr_i;
            if (issue) begin
                pc_q    <= pc_q + 4;
                count_q <= count_q + 1'b1;
            end
            // Sticky until reset
            if (run_i && !issue) begin
                done_q <= 1'b1;
            end
        end
    end

    assign if_id_o = if_id_q;
    assign done_o  = done_q;

endmodule

//--- hw/imem_loader.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module imem_loader (
    input  logic                   clk,
    input  logic                   rstn,
    input  core_bus_pkg::apb_req_t apb_req_i,
    input  logic [`IMEM_AW-1:0]    fetch_addr_i,
    input  logic                   done_i,
    output core_bus_pkg::apb_rsp_t apb_rsp_o,
    output logic [`XLEN-1:0]       fetch_instr_o,
    output logic                   run_o,
    output logic [`IMEM_AW:0]      prog_len_o
);

    logic [`XLEN-1:0]   imem [`IMEM_DEPTH];
    logic               run_q;
    logic [`IMEM_AW:0]  len_q;
    logic               access;
    logic               sel_ctrl;
    logic               sel_status;
    logic               sel_imem;
    logic               imem_busy;
    logic [`IMEM_AW-1:0] apb_word;

    assign access     = apb_req_i.psel && apb_req_i.penable;
    assign sel_ctrl   = apb_req_i.paddr == `CTRL_ADDR;
    assign sel_status = apb_req_i.paddr == `STATUS_ADDR;
    assign sel_imem   = (apb_req_i.paddr >= `IMEM_BASE) &&
                        (apb_req_i.paddr < `IMEM_BASE + 4 * `IMEM_DEPTH);
    assign apb_word   = apb_req_i.paddr[`IMEM_AW+1:2];

    // Program is frozen while the core runs
    assign imem_busy = sel_imem && apb_req_i.pwrite && run_q;

    always_ff @(posedge clk) begin
        if (access && apb_req_i.pwrite && sel_imem && !run_q) begin
            imem[apb_word] <= apb_req_i.pwdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_q <= 1'b0;
            len_q <= '0;
        end else if (access && apb_req_i.pwrite && sel_ctrl) begin
            run_q <= apb_req_i.pwdata[`CTRL_RUN_BIT];
            len_q <= apb_req_i.pwdata[`IMEM_AW:0];
        end
    end

    always_comb begin
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pslverr = access && (imem_busy || !(sel_ctrl || sel_status || sel_imem));
        if (sel_ctrl) begin
            apb_rsp_o.prdata = {run_q, {(`XLEN-`IMEM_AW-2){1'b0}}, len_q};
        end else if (sel_status) begin
            apb_rsp_o.prdata = {{(`XLEN-1){1'b0}}, done_i};
        end else if (sel_imem) begin
            apb_rsp_o.prdata = imem[apb_word];
        end
    end

    assign fetch_instr_o = imem[fetch_addr_i];
    assign run_o         = run_q;
    assign prog_len_o    = len_q;

endmodule

//--- hw/core_bus_pkg.sv
`include "core_defs.svh"

package core_bus_pkg;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [`APB_AW-1:0] paddr;
        logic [`XLEN-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic             pready;
        logic [`XLEN-1:0] prdata;
        logic             pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                      valid;
        logic [`XLEN-1:0]          pc;
        logic [`XLEN-1:0]          instr;
        riscv_isa_pkg::operation_e op;
        logic [`REG_AW-1:0]        rd;
        logic [`REG_AW-1:0]        rs1;
        logic [`REG_AW-1:0]        rs2;
        logic [`XLEN-1:0]          rs1_data;
        logic [`XLEN-1:0]          rs2_data;
        logic [`XLEN-1:0]          imm;
        logic                      we;
    } id_ex_t;

    // en is already qualified with rd != 0
    typedef struct packed {
        logic               en;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } reg_wr_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   instr;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   rd_data;
        logic               we;
    } retire_t;

endpackage

//--- hw/riscv_isa_pkg.sv
package riscv_isa_pkg;

    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    // Same instruction word seen through each format
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_u_t u;
    } instr_u;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [4:0] {
        OP_LUI, OP_AUIPC,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_OR, OP_AND, OP_SRL, OP_SRA,
        OP_UNKNOWN
    } operation_e;

endpackage

//--- hw/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath
`define XLEN        32
`define REG_AW      5

// Word addressed program memory
`define IMEM_DEPTH  256
`define IMEM_AW     8

`define RESET_PC    32'h0000_0000

// APB address map
`define APB_AW      12
`define CTRL_ADDR   12'h000
`define STATUS_ADDR 12'h004
`define IMEM_BASE   12'h400

// Run flag position in CTRL
`define CTRL_RUN_BIT 31

`endif
